// ==== Bender.yml ====
package:
  name: eeprom_ctrl

sources:
  - verilog/eeprom_cmd_pkg.sv
  - verilog/i2c_bus_pkg.sv
  - verilog/eeprom_req_dispatch.sv
  - verilog/eeprom_wr.sv
  - verilog/eeprom_resp_collect.sv
  - verilog/eeprom_ctrl_top.sv
  - target: test
    files:
      - tb/eeprom_model.sv
      - tb/tb_eeprom_ctrl.sv

// ==== tb.f ====
verilog/eeprom_cmd_pkg.sv
verilog/i2c_bus_pkg.sv
verilog/eeprom_req_dispatch.sv
verilog/eeprom_wr.sv
verilog/eeprom_resp_collect.sv
verilog/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/tb_eeprom_ctrl.sv

// ==== tb/eeprom_model.sv ====
`timescale 1ns/10ps
module eeprom_model #(
  parameter logic [7:0] FILL = 8'h00
) (
  input logic scl,
  inout wire  sda
);

  typedef enum {ph_idle, ph_ctrl, ph_addr, ph_wdata, ph_rdata} phase_t;

  logic [7:0] mem [2048];
  phase_t     phase;
  logic       pull;     // open drain, low or released
  logic       acking;
  logic       rd_mode;
  logic [2:0] blk;      // block bits from the control byte
  logic [7:0] word;
  logic [7:0] sh;
  int         cnt;

  assign sda = pull ? 1'b0 : 1'bz;

  initial begin
    for (int a = 0; a < 2048; a++) begin
      mem[a] = a[7:0] ^ {a[10:8], 5'd0} ^ FILL;
    end
    phase   = ph_idle;
    pull    = 1'b0;
    acking  = 1'b0;
    rd_mode = 1'b0;
    cnt     = 0;
  end

  // start and stop only count if scl is still high a moment later
  always @(negedge sda) begin
    #1;
    if (scl === 1'b1 && sda === 1'b0) begin
      phase  = ph_ctrl;
      cnt    = 0;
      acking = 1'b0;
      pull   = 1'b0;
    end
  end

  always @(posedge sda) begin
    #1;
    if (scl === 1'b1 && sda === 1'b1) begin
      phase  = ph_idle;
      acking = 1'b0;
      pull   = 1'b0;
    end
  end

  always @(posedge scl) begin
    if (phase == ph_rdata) begin
      if (cnt == 8) begin
        phase = ph_idle;  // master nak, single read only
      end else begin
        cnt = cnt + 1;
      end
    end else if (phase != ph_idle && !acking && cnt < 8) begin
      sh  = {sh[6:0], sda};
      cnt = cnt + 1;
    end
  end

  always @(negedge scl) begin
    if (phase == ph_rdata) begin
      if (cnt == 8) begin
        pull = 1'b0;  // let the master drive its ack slot
      end else begin
        sh   = {sh[6:0], 1'b0};
        pull = !sh[7];
      end
    end else if (acking) begin
      acking = 1'b0;
      pull   = 1'b0;
      cnt    = 0;
      case (phase)
        ph_ctrl: begin
          if (rd_mode) begin
            phase = ph_rdata;
            sh    = mem[{blk, word}];
            pull  = !sh[7];
          end else begin
            phase = ph_addr;
          end
        end
        ph_addr: phase = ph_wdata;
        default: phase = ph_idle;
      endcase
    end else if (phase != ph_idle && cnt == 8) begin
      acking = 1'b1;
      pull   = 1'b1;
      case (phase)
        ph_ctrl: begin
          blk     = sh[3:1];
          rd_mode = sh[0];
          if (sh[7:4] != i2c_bus_pkg::DEV_TYPE) begin
            acking = 1'b0;
            pull   = 1'b0;
            phase  = ph_idle;
          end
        end
        ph_addr: word = sh;
        default: mem[{blk, word}] = sh;
      endcase
    end
  end

endmodule

// ==== tb/tb_eeprom_ctrl.sv ====
`timescale 1ns/10ps
module tb_eeprom_ctrl;

  localparam int NUM_REQ = 300;
  localparam int MAX_CYC = NUM_REQ * 160 + 1000;
  localparam int NUM_DEV = 3;  // channel 3 has no part

  logic                              clk;
  logic                              rst_n;
  logic                              wr;
  logic                              rd;
  eeprom_cmd_pkg::ch_idx_t           ch;
  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr;
  logic [eeprom_cmd_pkg::DATA_W-1:0] wdata;
  logic [eeprom_cmd_pkg::NUM_CH-1:0] busy;
  logic                              ack;
  eeprom_cmd_pkg::eeprom_resp_t      resp;
  logic [eeprom_cmd_pkg::NUM_CH-1:0] scl;
  tri1  [eeprom_cmd_pkg::NUM_CH-1:0] sda;  // pull-ups

  logic [7:0]                        ref_mem [NUM_DEV][2048];
  eeprom_cmd_pkg::eeprom_resp_t      exp_q [$];
  logic [eeprom_cmd_pkg::NUM_CH-1:0] pending = '0;
  integer                            seed;
  int                                cycles = 0;
  int                                issued = 0;
  int                                dropped = 0;

  eeprom_ctrl_top dut (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .ch    (ch),
    .addr  (addr),
    .wdata (wdata),
    .busy  (busy),
    .ack   (ack),
    .resp  (resp),
    .scl   (scl),
    .sda   (sda)
  );

  for (genvar k = 0; k < NUM_DEV; k++) begin : g_dev
    eeprom_model #(.FILL(8'h5a ^ 8'(k))) u_dev (.scl(scl[k]), .sda(sda[k]));
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_resp(input eeprom_cmd_pkg::eeprom_resp_t got,
                            input eeprom_cmd_pkg::eeprom_resp_t exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH resp got %h exp %h", got, exp));
    end
  endtask

  task automatic check_busy(input logic [eeprom_cmd_pkg::NUM_CH-1:0] got,
                            input logic [eeprom_cmd_pkg::NUM_CH-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH busy got %h exp %h", got, exp));
    end
  endtask

  // power-on content of each part, every address bit matters
  function automatic logic [7:0] fill_byte(input int dev, input logic [10:0] a);
    return a[7:0] ^ {a[10:8], 5'd0} ^ (8'h5a ^ 8'(dev));
  endfunction

  // reference model update and expected response for one request
  task automatic book(input eeprom_cmd_pkg::ch_idx_t c, input logic is_rd,
                      input logic [10:0] a, input logic [7:0] d);
    eeprom_cmd_pkg::eeprom_resp_t e;
    e = '{ch: c, rd: is_rd, rdata: 8'hff, nak: 1'b0};
    if (c >= NUM_DEV) begin
      e.nak = 1'b1;  // nobody acks the control byte
    end else if (is_rd) begin
      e.rdata = ref_mem[c][a];
    end else begin
      ref_mem[c][a] = d;
    end
    exp_q.push_back(e);
    pending[c] = 1'b1;
  endtask

  task automatic send(input eeprom_cmd_pkg::ch_idx_t c, input logic w, input logic r,
                      input logic [10:0] a, input logic [7:0] d);
    @(posedge clk);
    wr    <= w;
    rd    <= r;
    ch    <= c;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr    <= 1'b0;
    rd    <= 1'b0;
  endtask

  task automatic issue(input eeprom_cmd_pkg::ch_idx_t c, input logic w, input logic r,
                       input logic [10:0] a, input logic [7:0] d);
    logic [eeprom_cmd_pkg::NUM_CH-1:0] mask;
    mask    = '0;
    mask[c] = 1'b1;
    book(c, r, a, d);
    send(c, w, r, a, d);
    // start pulses now, busy follows one cycle later
    @(negedge clk);
    @(negedge clk);
    check_busy(busy & mask, mask);
  endtask

  task automatic wait_idle(input eeprom_cmd_pkg::ch_idx_t c);
    do @(negedge clk); while (pending[c] || busy[c]);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYC) begin
      stop_run("timeout, requests still outstanding at the cycle limit");
    end
  end

  // match each ack to the oldest request of its channel
  always @(negedge clk) begin
    int idx;
    if (rst_n && ack) begin
      idx = -1;
      for (int i = exp_q.size() - 1; i >= 0; i--) begin
        if (exp_q[i].ch == resp.ch) idx = i;
      end
      if (idx < 0) begin
        stop_run($sformatf("ack on channel %0d with no request outstanding", resp.ch));
      end else begin
        check_resp(resp, exp_q[idx]);
        exp_q.delete(idx);
        pending[resp.ch] = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0]             r;
    eeprom_cmd_pkg::ch_idx_t c;
    logic [10:0]             a;
    logic [7:0]              d;
    seed  = 32'h9c96;
    rst_n = 1'b0;
    wr    = 1'b0;
    rd    = 1'b0;
    ch    = '0;
    addr  = '0;
    wdata = '0;
    for (int k = 0; k < NUM_DEV; k++) begin
      for (int i = 0; i < 2048; i++) ref_mem[k][i] = fill_byte(k, 11'(i));
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_busy(busy, '0);
    if (ack !== 1'b0) stop_run($sformatf("MISMATCH ack got %h exp 0", ack));
    if (scl !== '1) stop_run($sformatf("MISMATCH scl got %h exp f", scl));
    if (sda !== '1) stop_run($sformatf("MISMATCH sda got %h exp f", sda));

    issue(0, 1'b1, 1'b0, 11'h5a3, 8'h3c);
    wait_idle(0);
    issue(0, 1'b0, 1'b1, 11'h5a3, 8'h00);
    issue(3, 1'b1, 1'b0, 11'h7ff, 8'h81);  // empty channel
    wait_idle(0);
    wait_idle(3);
    issue(3, 1'b0, 1'b1, 11'h123, 8'h00);
    wait_idle(3);

    while (issued < NUM_REQ) begin
      @(negedge clk);
      r = $random(seed);
      c = r[1:0];
      a = {r[10:8], 5'd0, r[4:2]};  // all block bits, few words
      d = r[23:16];
      if (!pending[c] && !busy[c]) begin
        issue(c, r[13:12] != 2'b10, r[13], a, d);  // 11 is both strobes
        issued++;
      end else if (pending[c] && busy[c] && !ack && r[15:14] == 2'b00) begin
        send(c, 1'b1, 1'b0, a, ~d);  // must be dropped
        dropped++;
      end
    end

    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    check_busy(busy, '0);
    if (dropped == 0) begin
      stop_run("no strobe was ever sent to a busy channel");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== verilog/eeprom_cmd_pkg.sv ====
package eeprom_cmd_pkg;

  // channel engines behind one dispatcher
  localparam int NUM_CH = 4;

  localparam int ADDR_W = 11;  // 2 Kbyte part, block bits in addr[10:8]
  localparam int DATA_W = 8;

  typedef logic [$clog2(NUM_CH)-1:0] ch_idx_t;

  // host request as seen by the engines
  // read flag wins when wr and rd strobe together
  typedef struct packed {
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;  // don't care on reads
  } eeprom_req_t;

  // finished transaction, one per request
  typedef struct packed {
    ch_idx_t           ch;     // engine that ran it
    logic              rd;
    logic [DATA_W-1:0] rdata;  // ff unless the read reached the data phase
    logic              nak;    // device did not acknowledge some byte
  } eeprom_resp_t;

endpackage

// ==== verilog/eeprom_ctrl_top.sv ====
`timescale 1ns/10ps
module eeprom_ctrl_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wr,
  input  logic                                  rd,
  input  eeprom_cmd_pkg::ch_idx_t               ch,
  input  logic [eeprom_cmd_pkg::ADDR_W-1:0]     addr,
  input  logic [eeprom_cmd_pkg::DATA_W-1:0]     wdata,
  output logic [eeprom_cmd_pkg::NUM_CH-1:0]     busy,
  output logic                                  ack,
  output eeprom_cmd_pkg::eeprom_resp_t          resp,
  output logic [eeprom_cmd_pkg::NUM_CH-1:0]     scl,
  inout  wire  [eeprom_cmd_pkg::NUM_CH-1:0]     sda
);

  logic [eeprom_cmd_pkg::NUM_CH-1:0] start;
  logic [eeprom_cmd_pkg::NUM_CH-1:0] done;
  logic [eeprom_cmd_pkg::NUM_CH-1:0] take;
  eeprom_cmd_pkg::eeprom_req_t       req;
  eeprom_cmd_pkg::eeprom_resp_t      res [eeprom_cmd_pkg::NUM_CH];

  eeprom_req_dispatch u_dispatch (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .ch    (ch),
    .addr  (addr),
    .wdata (wdata),
    .busy  (busy),
    .start (start),
    .req   (req)
  );

  for (genvar k = 0; k < eeprom_cmd_pkg::NUM_CH; k++) begin : g_eng
    eeprom_wr u_eng (
      .clk   (clk),
      .rst_n (rst_n),
      .start (start[k]),
      .req   (req),
      .take  (take[k]),
      .ch_id (eeprom_cmd_pkg::ch_idx_t'(k)),
      .busy  (busy[k]),
      .done  (done[k]),
      .res   (res[k]),
      .scl   (scl[k]),
      .sda   (sda[k])
    );
  end

  eeprom_resp_collect u_collect (
    .clk   (clk),
    .rst_n (rst_n),
    .done  (done),
    .res   (res),
    .take  (take),
    .ack   (ack),
    .resp  (resp)
  );

endmodule

// ==== verilog/eeprom_req_dispatch.sv ====
`timescale 1ns/10ps
module eeprom_req_dispatch (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   wr,
  input  logic                                   rd,
  input  eeprom_cmd_pkg::ch_idx_t                ch,
  input  logic [eeprom_cmd_pkg::ADDR_W-1:0]      addr,
  input  logic [eeprom_cmd_pkg::DATA_W-1:0]      wdata,
  input  logic [eeprom_cmd_pkg::NUM_CH-1:0]      busy,
  output logic [eeprom_cmd_pkg::NUM_CH-1:0]      start,
  output eeprom_cmd_pkg::eeprom_req_t            req
);

  logic strobe;
  logic ch_free;
  logic accept;

  assign strobe = wr | rd;

  // engine raises busy one cycle after start, so cover that gap here
  assign ch_free = !busy[ch] && !start[ch];

  assign accept = strobe && ch_free;  // otherwise the strobe is dropped

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start <= '0;
    end else begin
      start <= '0;
      if (accept) begin
        start[ch] <= 1'b1;
      end
    end
  end

  // shared by all engines, each one latches it on its own start
  always_ff @(posedge clk) begin
    if (accept) begin
      req.rd    <= rd;
      req.addr  <= addr;
      req.wdata <= wdata;
    end
  end

endmodule

// ==== verilog/eeprom_resp_collect.sv ====
`timescale 1ns/10ps
module eeprom_resp_collect (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [eeprom_cmd_pkg::NUM_CH-1:0]     done,
  input  eeprom_cmd_pkg::eeprom_resp_t          res [eeprom_cmd_pkg::NUM_CH],
  output logic [eeprom_cmd_pkg::NUM_CH-1:0]     take,
  output logic                                  ack,
  output eeprom_cmd_pkg::eeprom_resp_t          resp
);

  logic [eeprom_cmd_pkg::NUM_CH-1:0] pend;
  eeprom_cmd_pkg::eeprom_resp_t      store [eeprom_cmd_pkg::NUM_CH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~take) | done;
    end
  end

  // engine stays busy until take, so a slot is never refilled early
  always_ff @(posedge clk) begin
    for (int k = 0; k < eeprom_cmd_pkg::NUM_CH; k++) begin
      if (done[k]) begin
        store[k] <= res[k];
      end
    end
  end

  // lowest pending channel wins
  always_comb begin
    take = '0;
    resp = store[0];
    for (int k = eeprom_cmd_pkg::NUM_CH - 1; k >= 0; k--) begin
      if (pend[k]) begin
        take    = '0;
        take[k] = 1'b1;
        resp    = store[k];
      end
    end
  end

  assign ack = |pend;

endmodule

// ==== verilog/eeprom_wr.sv ====
`timescale 1ns/10ps
module eeprom_wr (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  eeprom_cmd_pkg::eeprom_req_t   req,
  input  logic                          take,
  input  eeprom_cmd_pkg::ch_idx_t       ch_id,
  output logic                          busy,
  output logic                          done,
  output eeprom_cmd_pkg::eeprom_resp_t  res,
  output logic                          scl,
  inout  wire                           sda
);

  i2c_bus_pkg::eng_state_t state;
  i2c_bus_pkg::eng_state_t nxt_byte;   // where to go after an ack slot

  logic [7:0] pre;       // quarter prescaler
  logic [1:0] q;         // quarter within the bit
  logic [3:0] bit_cnt;   // 0..7 data, 8 ack
  logic [7:0] sh;
  logic [7:0] rdata_r;
  logic       nak_r;
  logic       pend;      // result waits for take
  eeprom_cmd_pkg::eeprom_req_t req_r;

  logic tick;
  logic bit_end;
  logic smp;
  logic ack_bit;
  logic byte_out;
  logic pull_low;

  assign tick     = (pre == 8'(i2c_bus_pkg::QTR - 1));
  assign bit_end  = tick && (q == i2c_bus_pkg::Q_LAST);
  assign smp      = tick && (q == i2c_bus_pkg::Q_SAMPLE);
  assign ack_bit  = (bit_cnt == i2c_bus_pkg::ACK_BIT);
  assign byte_out = (state == i2c_bus_pkg::st_ctrl) || (state == i2c_bus_pkg::st_addr) ||
                    (state == i2c_bus_pkg::st_wdata) || (state == i2c_bus_pkg::st_ctrl_rd);

  // successor of a finished byte, any nak cuts the transfer short
  always_comb begin
    case (state)
      i2c_bus_pkg::st_ctrl:    nxt_byte = i2c_bus_pkg::st_addr;
      i2c_bus_pkg::st_addr:    nxt_byte = req_r.rd ? i2c_bus_pkg::st_rstart
                                                   : i2c_bus_pkg::st_wdata;
      i2c_bus_pkg::st_ctrl_rd: nxt_byte = i2c_bus_pkg::st_rdata;
      default:                 nxt_byte = i2c_bus_pkg::st_stop;
    endcase
    if (nak_r) begin
      nxt_byte = i2c_bus_pkg::st_stop;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= i2c_bus_pkg::st_idle;
      pre     <= '0;
      q       <= '0;
      bit_cnt <= '0;
      nak_r   <= 1'b0;
      pend    <= 1'b0;
    end else begin
      if (take) begin
        pend <= 1'b0;
      end
      if (state == i2c_bus_pkg::st_idle) begin
        pre     <= '0;
        q       <= '0;
        bit_cnt <= '0;
        if (start) begin
          state <= i2c_bus_pkg::st_start;
          nak_r <= 1'b0;
        end
      end else begin
        pre <= tick ? '0 : pre + 8'd1;
        if (tick) begin
          q <= q + 2'd1;
        end
        if (smp && byte_out && ack_bit) begin
          nak_r <= nak_r | sda;  // released ack slot reads high
        end
        if (bit_end) begin
          case (state)
            i2c_bus_pkg::st_start: begin
              state   <= i2c_bus_pkg::st_ctrl;
              bit_cnt <= '0;
            end
            i2c_bus_pkg::st_rstart: begin
              state   <= i2c_bus_pkg::st_ctrl_rd;
              bit_cnt <= '0;
            end
            i2c_bus_pkg::st_stop: begin
              state <= i2c_bus_pkg::st_idle;
              pend  <= 1'b1;
            end
            default: begin
              if (ack_bit) begin
                state   <= nxt_byte;
                bit_cnt <= '0;
              end else begin
                bit_cnt <= bit_cnt + 4'd1;
              end
            end
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == i2c_bus_pkg::st_idle && start) begin
      req_r   <= req;
      rdata_r <= 8'hff;
    end
    if (smp && state == i2c_bus_pkg::st_rdata && !ack_bit) begin
      sh <= {sh[6:0], sda};
    end
    if (bit_end) begin
      if (state == i2c_bus_pkg::st_start) begin
        sh <= {i2c_bus_pkg::DEV_TYPE, req_r.addr[eeprom_cmd_pkg::ADDR_W-1 -: 3], 1'b0};
      end else if (state == i2c_bus_pkg::st_rstart) begin
        sh <= {i2c_bus_pkg::DEV_TYPE, req_r.addr[eeprom_cmd_pkg::ADDR_W-1 -: 3], 1'b1};
      end else if (byte_out && !ack_bit) begin
        sh <= {sh[6:0], 1'b0};  // msb first
      end else if (state == i2c_bus_pkg::st_ctrl && ack_bit) begin
        sh <= req_r.addr[7:0];
      end else if (state == i2c_bus_pkg::st_addr && ack_bit) begin
        sh <= req_r.wdata;
      end else if (state == i2c_bus_pkg::st_rdata && ack_bit) begin
        rdata_r <= sh;
      end
    end
  end

  // open-drain drive, changes land in quarter 0
  always_comb begin
    case (state)
      i2c_bus_pkg::st_start,
      i2c_bus_pkg::st_rstart:  pull_low = (q == i2c_bus_pkg::Q_LAST);  // fall, scl high
      i2c_bus_pkg::st_stop:    pull_low = (q != i2c_bus_pkg::Q_LAST);  // rise, scl high
      i2c_bus_pkg::st_ctrl,
      i2c_bus_pkg::st_addr,
      i2c_bus_pkg::st_wdata,
      i2c_bus_pkg::st_ctrl_rd: pull_low = !ack_bit && !sh[7];
      default:                 pull_low = 1'b0;  // rdata and master nak
    endcase
  end

  assign sda  = pull_low ? 1'b0 : 1'bz;
  assign scl  = (state == i2c_bus_pkg::st_idle) || (q >= i2c_bus_pkg::Q_SCL_HI);
  assign done = (state == i2c_bus_pkg::st_stop) && bit_end;
  assign busy = (state != i2c_bus_pkg::st_idle) || pend;

  assign res = '{ch: ch_id, rd: req_r.rd, rdata: rdata_r, nak: nak_r};

endmodule

// ==== verilog/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

  // clk cycles per quarter SCL period, so a bit takes 4*QTR cycles
  localparam int QTR = 1;

  localparam logic [1:0] Q_SCL_HI = 2'd2;  // scl high from this quarter on
  localparam logic [1:0] Q_SAMPLE = 2'd2;  // slave data read while scl high
  localparam logic [1:0] Q_LAST   = 2'd3;

  // bit index of the acknowledge slot after 8 data bits
  localparam logic [3:0] ACK_BIT = 4'd8;

  // 24Cxx device type in the upper control-byte nibble
  localparam logic [3:0] DEV_TYPE = 4'b1010;

  typedef enum logic [3:0] {
    st_idle,
    st_start,
    st_ctrl,     // control byte, write direction
    st_addr,     // word address, low 8 bits
    st_wdata,
    st_rstart,   // repeated start before a read
    st_ctrl_rd,
    st_rdata,
    st_stop
  } eng_state_t;

endpackage
